// File: compile.f
+incdir+sim
verilog/oflow_pkg.sv
verilog/oflow_cand_fifo.sv
verilog/oflow_score_board.sv
verilog/oflow_row_counter.sv
verilog/oflow_conflict_resolve.sv
verilog/oflow_reg_fsm.sv
verilog/oflow_registration_top.sv
sim/oflow_tb.sv

// File: sim/oflow_tb_table.svh
`ifndef OFLOW_TB_TABLE_SVH
`define OFLOW_TB_TABLE_SVH

// --------------------------------------------------
// frame table, one cand_t per row
// --------------------------------------------------

localparam int n_frames = 6;

typedef logic [id_len-1:0] id_arr_t [max_rows];

cand_t frame_tab [n_frames][max_rows];
logic burst_tab [n_frames]; // 1 -> beats back to back, no gaps

function automatic void build_table();
	for (int f = 0; f < n_frames; f++) begin
		burst_tab[f] = (f == 5); // last frame is one long burst
		for (int r = 0; r < max_rows; r++) begin
			frame_tab[f][r].score_0 = score_len'(10 + 7 * r + f);
			frame_tab[f][r].id_0 = id_len'(8 * f + r); // distinct in a frame
			frame_tab[f][r].score_1 = score_len'(200);
			frame_tab[f][r].id_1 = id_len'(48 + r); // runner up
		end
	end
	// frame 1, rows 2 and 5 share an id, row 2 is worse
	frame_tab[1][5].id_0 = frame_tab[1][2].id_0;
	frame_tab[1][2].score_0 = 8'd40;
	frame_tab[1][5].score_0 = 8'd20;
	// frame 2, equal scores so the later row falls back
	frame_tab[2][3].id_0 = frame_tab[2][1].id_0;
	frame_tab[2][1].score_0 = 8'd25;
	frame_tab[2][3].score_0 = 8'd25;
	// frame 3, three rows on one id
	frame_tab[3][2].id_0 = frame_tab[3][0].id_0;
	frame_tab[3][4].id_0 = frame_tab[3][0].id_0;
	frame_tab[3][0].score_0 = 8'd30;
	frame_tab[3][2].score_0 = 8'd10;
	frame_tab[3][4].score_0 = 8'd20;
	// frame 4 stays distinct, checks the clear
	// frame 5, burst with a tie on the last two rows
	frame_tab[5][7].id_0 = frame_tab[5][6].id_0;
	frame_tab[5][6].score_0 = 8'd50;
	frame_tab[5][7].score_0 = 8'd50;
endfunction

// --------------------------------------------------
// reference model, pairs walked a<b in order
// --------------------------------------------------

function automatic id_arr_t expect_ids(int f);
	id_arr_t ids;
	logic fell [max_rows]; // row already on its second choice
	for (int r = 0; r < max_rows; r++) begin
		fell[r] = 1'b0;
		ids[r] = frame_tab[f][r].id_0;
	end
	for (int a = 0; a < max_rows - 1; a++)
		for (int b = a + 1; b < max_rows; b++)
			if (ids[a] == ids[b] && !fell[a] && !fell[b]) begin
				if (frame_tab[f][a].score_0 > frame_tab[f][b].score_0) begin
					fell[a] = 1'b1; // larger score loses
					ids[a] = frame_tab[f][a].id_1;
				end else begin
					fell[b] = 1'b1; // tie goes against b
					ids[b] = frame_tab[f][b].id_1;
				end
			end
	return ids;
endfunction

`endif

// File: sim/oflow_tb.sv
`timescale 1ns/100ps

module oflow_tb;

	import oflow_pkg::*;

	localparam int max_rows = max_rows_default;
	localparam int credits = credits_default;
	localparam int row_len = $clog2(max_rows);

	`include "oflow_tb_table.svh"

	// frame budget plus reset
	localparam int wd_cycles = n_frames * (max_rows * max_rows + 40) + 8;

	logic clk, reset_N, frame_start, cand_valid, credit_return, frame_done;
	cand_t cand;
	logic [row_len-1:0] row_sel;
	logic [id_len-1:0] id_sel;
	logic [id_len-1:0] id_out [max_rows];

	integer seed = 32'h566e_c99e; // gap pattern
	int sent_cnt = 0;  // beats sent over the run
	int ret_cnt = 0;   // credit_return pulses over the run
	int errors = 0;

	oflow_registration_top #(.max_rows(max_rows), .credits(credits)) DUT (
		.clk(clk), .reset_N(reset_N), .frame_start(frame_start),
		.cand_valid(cand_valid), .cand(cand), .credit_return(credit_return),
		.row_sel(row_sel), .id_sel(id_sel), .id_out(id_out), .frame_done(frame_done)
	);

	always #10 clk = ~clk; // 20 ns period

// --------------------------------------------------
// checks
// --------------------------------------------------

	task automatic abort_run();
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_id(string name, logic [id_len-1:0] exp, logic [id_len-1:0] act);
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s expected %0d actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (exp != act) begin
			errors++;
			$display("[FAIL] %s expected %0d actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	// credit monitor counts at the edge for the driver 2 ns later
	always @(posedge clk) begin
		if (reset_N && credit_return) begin
			ret_cnt++;
			if (ret_cnt > sent_cnt) begin
				errors++;
				$display("credit_return seen with no beat outstanding");
				abort_run();
			end
		end
	end

// --------------------------------------------------
// driver
// --------------------------------------------------

	// called 2 ns after an edge, returns 2 ns after the next one
	task automatic pulse_frame_start();
		frame_start = 1'b1;
		@(posedge clk);
		#2 frame_start = 1'b0;
	endtask

	task automatic send_frame(int f);
		int gap;
		logic started;
		@(posedge clk);
		#2;
		started = !burst_tab[f]; // a burst frame is queued while idle
		if (started)
			pulse_frame_start();
		for (int r = 0; r < max_rows; r++) begin
			gap = burst_tab[f] ? 0 : ($random(seed) & 3);
			repeat (gap) begin
				@(posedge clk);
				#2;
			end
			while (sent_cnt - ret_cnt >= credits) begin // stall while out of credits
				if (!started) begin
					// fifo full while idle, release the frame now
					started = 1'b1;
					pulse_frame_start();
				end else begin
					@(posedge clk);
					#2;
				end
			end
			cand_valid = 1'b1;
			cand = frame_tab[f][r];
			sent_cnt++;
			@(posedge clk);
			#2 cand_valid = 1'b0;
		end
	endtask

	task automatic check_frame(int f, int ret_start);
		id_arr_t exp;
		exp = expect_ids(f);
		while (!frame_done) begin
			@(posedge clk);
			#2;
		end
		check_count($sformatf("frame %0d credit_return pulses", f), max_rows,
			ret_cnt - ret_start);
		for (int r = 0; r < max_rows; r++) begin
			check_id($sformatf("frame %0d id_out[%0d]", f, r), exp[r], id_out[r]);
			@(posedge clk);
			#2 row_sel = row_len'(r); // read port one row per cycle
			#1 check_id($sformatf("frame %0d id_sel row %0d", f, r), exp[r], id_sel);
		end
	endtask

	initial begin
		int ret_start;
		clk = 1'b0;
		reset_N = 1'b0;
		frame_start = 1'b0;
		cand_valid = 1'b0;
		cand = '0;
		row_sel = '0;
		build_table();
		repeat (8) @(posedge clk);
		#2 reset_N = 1'b1;
		for (int f = 0; f < n_frames; f++) begin
			ret_start = ret_cnt;
			send_frame(f);
			check_frame(f, ret_start);
		end
		if (errors == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			abort_run();
		end
	end

	// watchdog
	initial begin
		#(wd_cycles * 20);
		$display("run timed out after %0d cycles", wd_cycles);
		abort_run();
	end

endmodule

// File: verilog/oflow_cand_fifo.sv
`timescale 1ns/100ps

module oflow_cand_fifo #(
	parameter int credits = oflow_pkg::credits_default
) (
	input logic clk,
	input logic reset_N,
	input logic push,                      // cand_valid from the link
	input oflow_pkg::cand_t push_data,
	input logic pop,                       // from the fsm
	output oflow_pkg::cand_t pop_data,     // head of queue, comb
	output logic empty,
	output logic credit_return             // one pulse per pop
);

	import oflow_pkg::*;

	localparam int ptr_len = (credits > 1) ? $clog2(credits) : 1;
	localparam int cnt_len = $clog2(credits + 1);

// --------------------------------------------------
// storage and pointers
// --------------------------------------------------

	cand_t mem [credits]; // payload, no reset
	logic [ptr_len-1:0] wr_ptr;
	logic [ptr_len-1:0] rd_ptr;
	logic [cnt_len-1:0] count;
	logic full;

	assign empty = (count == '0);
	assign full = (count == cnt_len'(credits));
	assign pop_data = mem[rd_ptr]; // popped entry written same edge

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			if (push) // wrap at credits, depth need not be a power of two
				wr_ptr <= (wr_ptr == ptr_len'(credits - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_len'(credits - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
			credit_return <= pop; // registered, one cycle per pop
		end
	end

// --------------------------------------------------
// link checks
// --------------------------------------------------

	// sender must hold a credit, so a full queue never sees a push
	a_no_push_full: assert property (@(posedge clk) disable iff (!reset_N)
		push |-> !full);

	// fsm only pops a non-empty queue
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_N)
		pop |-> !empty);

endmodule

// File: verilog/oflow_conflict_resolve.sv
`timescale 1ns/100ps

module oflow_conflict_resolve #(
	parameter int max_rows = oflow_pkg::max_rows_default,
	localparam int row_len = $clog2(max_rows)
) (
	input logic enable,                      // resolve state
	input logic [row_len-1:0] row_a,
	input logic [row_len-1:0] row_b,
	input oflow_pkg::row_entry_t entry_a,
	input oflow_pkg::row_entry_t entry_b,
	output logic ptr_write,
	output logic [row_len-1:0] ptr_row,
	output logic ptr_val
);

	import oflow_pkg::*;

	logic [id_len-1:0] sel_a; // currently selected ids
	logic [id_len-1:0] sel_b;
	cr_verdict_t verdict;

// --------------------------------------------------
// pair compare
// --------------------------------------------------

	assign sel_a = entry_a.ptr ? entry_a.cand.id_1 : entry_a.cand.id_0;
	assign sel_b = entry_b.ptr ? entry_b.cand.id_1 : entry_b.cand.id_0;

	always_comb begin
		verdict = cr_keep;
		// only rows still on their first choice can fall back
		if (enable && (sel_a == sel_b) && !entry_a.ptr && !entry_b.ptr) begin
			if (entry_a.cand.score_0 > entry_b.cand.score_0)
				verdict = cr_flip_first;  // a is the worse match
			else
				verdict = cr_flip_second; // b worse or tie
		end
	end

// --------------------------------------------------
// pointer write
// --------------------------------------------------

	always_comb begin
		ptr_write = 1'b0;
		ptr_row = row_b;
		ptr_val = 1'b0;
		case (verdict)
			cr_flip_first: begin
				ptr_write = 1'b1;
				ptr_row = row_a;
				ptr_val = 1'b1; // point at id_1
			end
			cr_flip_second: begin
				ptr_write = 1'b1;
				ptr_row = row_b;
				ptr_val = 1'b1;
			end
			default: ptr_write = 1'b0; // keep
		endcase
	end

endmodule

// File: verilog/oflow_pkg.sv
package oflow_pkg;

// --------------------------------------------------
// widths and defaults
// --------------------------------------------------

	localparam int score_len = 8;        // match score, lower is better
	localparam int id_len = 6;           // object id width
	localparam int max_rows_default = 8; // rows per frame
	localparam int credits_default = 4;  // also the fifo depth

// --------------------------------------------------
// candidate record from the similarity stage
// --------------------------------------------------

	// first pair is the best match, second pair the runner up
	typedef struct packed {
		logic [score_len-1:0] score_0;
		logic [id_len-1:0] id_0;
		logic [score_len-1:0] score_1;
		logic [id_len-1:0] id_1;
	} cand_t;

	// one score board row
	typedef struct packed {
		cand_t cand;
		logic ptr; // 0 -> id_0, 1 -> id_1
	} row_entry_t;

// --------------------------------------------------
// state and verdict encodings
// --------------------------------------------------

	typedef enum logic [1:0] {
		st_idle,
		st_load,    // filling the score board
		st_resolve, // walking row pairs
		st_done     // one cycle, frame_done
	} reg_state_t;

	// outcome of one row pair
	typedef enum logic [1:0] {
		cr_keep,
		cr_flip_first,  // row a falls back
		cr_flip_second  // row b falls back
	} cr_verdict_t;

endpackage

// File: verilog/oflow_reg_fsm.sv
`timescale 1ns/100ps

module oflow_reg_fsm (
	input logic clk,
	input logic reset_N,
	input logic frame_start,
	input logic fifo_empty,
	input logic cnt_last,
	output logic fifo_pop,
	output logic sb_write,
	output logic sb_clear,
	output logic cnt_clear,
	output logic cnt_step,
	output logic cnt_mode,
	output logic resolve_en,
	output logic frame_done
);

	import oflow_pkg::*;

	reg_state_t state;
	reg_state_t state_nxt;

// --------------------------------------------------
// state register
// --------------------------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			state <= st_idle;
		else
			state <= state_nxt;
	end

// --------------------------------------------------
// next state and strobes
// --------------------------------------------------

	always_comb begin
		state_nxt = state;
		fifo_pop = 1'b0;
		sb_write = 1'b0;
		sb_clear = 1'b0;
		cnt_clear = 1'b0;
		cnt_step = 1'b0;
		cnt_mode = (state == st_resolve); // pairs only while resolving
		resolve_en = 1'b0;
		frame_done = 1'b0;

		case (state)
			st_idle: ; // candidates wait in the fifo
			st_load: begin
				if (!fifo_empty) begin
					fifo_pop = 1'b1;
					sb_write = 1'b1; // same edge as the pop
					if (cnt_last) begin
						cnt_clear = 1'b1; // restart as pair walk
						state_nxt = st_resolve;
					end else begin
						cnt_step = 1'b1;
					end
				end
			end
			st_resolve: begin
				resolve_en = 1'b1;
				cnt_step = 1'b1; // one pair per cycle
				if (cnt_last)
					state_nxt = st_done;
			end
			st_done: begin
				frame_done = 1'b1;
				state_nxt = st_idle;
			end
			default: state_nxt = st_idle;
		endcase

		// new frame, restarts load from any state but resolve
		if (frame_start && (state != st_resolve)) begin
			sb_clear = 1'b1;
			cnt_clear = 1'b1;
			fifo_pop = 1'b0;
			sb_write = 1'b0;
			cnt_step = 1'b0;
			state_nxt = st_load;
		end
	end

	// upstream waits for frame_done before the next frame
	a_no_start_resolve: assert property (@(posedge clk) disable iff (!reset_N)
		(state == st_resolve) |-> !frame_start);

endmodule

// File: verilog/oflow_registration_top.sv
`timescale 1ns/100ps

module oflow_registration_top #(
	parameter int max_rows = oflow_pkg::max_rows_default,
	parameter int credits = oflow_pkg::credits_default,
	localparam int row_len = $clog2(max_rows)
) (
	input logic clk,
	input logic reset_N,
	input logic frame_start,
	input logic cand_valid,
	input oflow_pkg::cand_t cand,
	output logic credit_return,
	input logic [row_len-1:0] row_sel,
	output logic [oflow_pkg::id_len-1:0] id_sel,
	output logic [oflow_pkg::id_len-1:0] id_out [max_rows],
	output logic frame_done
);

	import oflow_pkg::*;

// --------------------------------------------------
// internal wires
// --------------------------------------------------

	cand_t fifo_data;
	logic fifo_pop, fifo_empty;
	logic sb_write, sb_clear;
	logic cnt_clear, cnt_step, cnt_mode, cnt_last;
	logic resolve_en;
	logic [row_len-1:0] row_idx, pair_a, pair_b;
	row_entry_t entry_a, entry_b;
	logic ptr_write, ptr_val;
	logic [row_len-1:0] ptr_row;

// --------------------------------------------------
// blocks
// --------------------------------------------------

	oflow_cand_fifo #(.credits(credits)) u_fifo (
		.clk(clk), .reset_N(reset_N),
		.push(cand_valid), .push_data(cand),
		.pop(fifo_pop), .pop_data(fifo_data),
		.empty(fifo_empty), .credit_return(credit_return)
	);

	oflow_reg_fsm u_fsm (
		.clk(clk), .reset_N(reset_N),
		.frame_start(frame_start), .fifo_empty(fifo_empty), .cnt_last(cnt_last),
		.fifo_pop(fifo_pop), .sb_write(sb_write), .sb_clear(sb_clear),
		.cnt_clear(cnt_clear), .cnt_step(cnt_step), .cnt_mode(cnt_mode),
		.resolve_en(resolve_en), .frame_done(frame_done)
	);

	oflow_row_counter #(.max_rows(max_rows)) u_cnt (
		.clk(clk), .reset_N(reset_N),
		.clear(cnt_clear), .step(cnt_step), .mode(cnt_mode),
		.row_idx(row_idx), .pair_a(pair_a), .pair_b(pair_b), .last(cnt_last)
	);

	oflow_score_board #(.max_rows(max_rows)) u_sb (
		.clk(clk), .reset_N(reset_N),
		.clear(sb_clear), .write(sb_write), .write_row(row_idx), .write_data(fifo_data),
		.row_a(pair_a), .row_b(pair_b), .entry_a(entry_a), .entry_b(entry_b),
		.ptr_write(ptr_write), .ptr_row(ptr_row), .ptr_val(ptr_val),
		.id_out(id_out), .row_sel(row_sel), .id_sel(id_sel)
	);

	oflow_conflict_resolve #(.max_rows(max_rows)) u_cr (
		.enable(resolve_en), .row_a(pair_a), .row_b(pair_b),
		.entry_a(entry_a), .entry_b(entry_b),
		.ptr_write(ptr_write), .ptr_row(ptr_row), .ptr_val(ptr_val)
	);

endmodule

// File: verilog/oflow_row_counter.sv
`timescale 1ns/100ps

module oflow_row_counter #(
	parameter int max_rows = oflow_pkg::max_rows_default,
	localparam int row_len = $clog2(max_rows)
) (
	input logic clk,
	input logic reset_N,
	input logic clear,
	input logic step,
	input logic mode,                  // 0 rows, 1 pairs
	output logic [row_len-1:0] row_idx,
	output logic [row_len-1:0] pair_a,
	output logic [row_len-1:0] pair_b,
	output logic last
);

	localparam logic [row_len-1:0] last_row = row_len'(max_rows - 1);
	localparam logic [row_len-1:0] last_a = row_len'(max_rows - 2);

// --------------------------------------------------
// row and pair counters
// --------------------------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			row_idx <= '0;
			pair_a <= '0;
			pair_b <= row_len'(1);
		end else if (clear) begin // restart, first pair is (0,1)
			row_idx <= '0;
			pair_a <= '0;
			pair_b <= row_len'(1);
		end else if (step) begin
			if (!mode) begin
				row_idx <= row_idx + 1'b1; // load, one row per write
			end else if (pair_b == last_row) begin
				// end of inner walk, next a
				pair_a <= pair_a + 1'b1;
				pair_b <= pair_a + row_len'(2);
			end else begin
				pair_b <= pair_b + 1'b1;
			end
		end
	end

// --------------------------------------------------
// last flag
// --------------------------------------------------

	always_comb begin
		if (!mode)
			last = (row_idx == last_row);
		else
			last = (pair_a == last_a) && (pair_b == last_row); // final pair
	end

	// pair walk keeps a below b
	a_pair_order: assert property (@(posedge clk) disable iff (!reset_N)
		mode |-> (pair_a < pair_b));

endmodule

// File: verilog/oflow_score_board.sv
`timescale 1ns/100ps

module oflow_score_board #(
	parameter int max_rows = oflow_pkg::max_rows_default,
	localparam int row_len = $clog2(max_rows)
) (
	input logic clk,
	input logic reset_N,
	// load side
	input logic clear,                          // frame_start
	input logic write,
	input logic [row_len-1:0] write_row,
	input oflow_pkg::cand_t write_data,
	// resolver side
	input logic [row_len-1:0] row_a,
	input logic [row_len-1:0] row_b,
	output oflow_pkg::row_entry_t entry_a,
	output oflow_pkg::row_entry_t entry_b,
	input logic ptr_write,
	input logic [row_len-1:0] ptr_row,
	input logic ptr_val,
	// results
	output logic [oflow_pkg::id_len-1:0] id_out [max_rows],
	input logic [row_len-1:0] row_sel,
	output logic [oflow_pkg::id_len-1:0] id_sel
);

	import oflow_pkg::*;

// --------------------------------------------------
// row registers
// --------------------------------------------------

	cand_t cand_reg [max_rows]; // scores and ids
	logic ptr_reg [max_rows];   // selects id_0 or id_1

	// payload, zeroed by clear only
	always_ff @(posedge clk) begin
		if (clear) begin
			for (int i = 0; i < max_rows; i++)
				cand_reg[i] <= '0;
		end else if (write) begin
			cand_reg[write_row] <= write_data;
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int i = 0; i < max_rows; i++)
				ptr_reg[i] <= 1'b0;
		end else if (clear) begin
			for (int i = 0; i < max_rows; i++)
				ptr_reg[i] <= 1'b0;
		end else if (write) begin
			ptr_reg[write_row] <= 1'b0; // new candidate starts on id_0
		end else if (ptr_write) begin
			ptr_reg[ptr_row] <= ptr_val; // fallback from resolver
		end
	end

// --------------------------------------------------
// read side
// --------------------------------------------------

	// pair for the resolver, updated pointer seen next cycle
	always_comb begin
		entry_a.cand = cand_reg[row_a];
		entry_a.ptr = ptr_reg[row_a];
		entry_b.cand = cand_reg[row_b];
		entry_b.ptr = ptr_reg[row_b];
	end

	// selected id per row
	always_comb begin
		for (int i = 0; i < max_rows; i++)
			id_out[i] = ptr_reg[i] ? cand_reg[i].id_1 : cand_reg[i].id_0;
	end

	assign id_sel = id_out[row_sel]; // read port, comb

	// load and resolve phases never overlap
	a_no_write_clash: assert property (@(posedge clk) disable iff (!reset_N)
		!(write && ptr_write));

endmodule
